//--- flist.f
logic/axi_pkg.sv
logic/mem_pkg.sv
logic/ar_issue.sv
logic/r_beat_ctrl.sv
logic/burst_addr_gen.sv
logic/local_mem.sv
logic/axi_rd_master_top.sv
verif/axi_rd_master_properties.sv
verif/tb_axi_rd_master.sv

//--- run.sh
#!/bin/sh
# Build and run the AXI read master testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_axi_rd_master \
    -f flist.f \
    -Mdir obj_dir \
    -o tb_axi_rd_master_sim

./obj_dir/tb_axi_rd_master_sim > sim.log 2>&1 || true
cat sim.log

# A run cut short by an assertion never reaches the pass line
if grep -q "Simulation FAILED" sim.log; then
    exit 1
fi
if ! grep -q "Simulation PASSED" sim.log; then
    exit 1
fi
exit 0

//--- verif/tb_axi_rd_master.sv
`timescale 1ns/1ps

module tb_axi_rd_master;
    import axi_pkg::*;
    import mem_pkg::*;

    localparam int MEM_AW     = 12;
    localparam int MEM_BYTES  = 1 << MEM_AW;
    // Far above the total length of all tests
    localparam int MAX_CYCLES = 20000;

    logic              clk;
    logic              rst_n;
    ar_req_t           req_i;
    logic              req_valid_i;
    logic              arready_i;
    r_beat_t           rbeat_i;
    logic              rvalid_i;
    logic [MEM_AW-1:0] mem_raddr_i;
    ar_req_t           ar_o;
    logic              arvalid_o;
    logic              rready_o;
    logic              busy_o;
    logic              done_o;
    axi_resp_t         resp_o;
    byte_t             mem_rdata_o;

    byte_t             model [MEM_BYTES];
    axi_data_t         beat_q [$];
    logic [MEM_AW-1:0] touched_q [$];
    logic [31:0]       rng_state = 32'd70;
    int                cycles;
    int                done_cnt;
    int                ar_cnt;
    logic              arvalid_prev;
    axi_resp_t         done_resp;
    logic              done_busy;
    int                cmp_req;
    int                cmp_done;
    string             cmp_name;
    ar_req_t           exp_req;
    ar_req_t           seen_ar;
    logic              ar_expected;
    int                exp_ar_cnt;
    axi_resp_t         exp_resp;
    logic              busy_seen;
    logic              busy_at_ar;
    int                rready_miss;
    int                checks;
    int                errors;
    int                tests;

    axi_rd_master_top #(
        .MEM_AW (MEM_AW)
    ) u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Simulation FAILED");
            $finish;
        end
    end

    // Mid-cycle counters for AR issues and completions
    always @(negedge clk) begin
        arvalid_prev <= arvalid_o;
        if (arvalid_o && !arvalid_prev) begin
            ar_cnt <= ar_cnt + 1;
        end
        if (done_o) begin
            done_cnt  <= done_cnt + 1;
            done_resp <= resp_o;
            done_busy <= busy_o;
        end
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic ar_req_t build_req(input axi_id_t id, input axi_addr_t addr,
                                          input axi_len_t len, input axi_size_t size,
                                          input axi_burst_t burst);
        ar_req_t r;
        r.id    = id;
        r.addr  = addr;
        r.len   = len;
        r.size  = size;
        r.burst = burst;
        return r;
    endfunction

    // Only beat 1 carries the test's chosen response
    function automatic axi_resp_t beat_resp(input int b, input axi_resp_t mid_resp);
        return (b == 1) ? mid_resp : RESP_OKAY;
    endfunction

    // Reference model of beat addresses per burst type and the low (1 << size) lanes
    function automatic void apply_burst(input ar_req_t req);
        axi_addr_t         step;
        axi_addr_t         bound;
        axi_addr_t         low;
        axi_addr_t         addr;
        axi_data_t         data;
        logic              wrap;
        logic [MEM_AW-1:0] idx;
        int                b;
        int                k;
        step  = axi_addr_t'(1) << req.size;
        bound = (axi_addr_t'(req.len) + 32'd1) << req.size;
        low   = req.addr - (req.addr % bound);
        wrap  = (req.burst == BURST_WRAP) && (req.len inside {4'd1, 4'd3, 4'd7, 4'd15});
        touched_q.delete();
        for (b = 0; b <= int'(req.len); b++) begin
            if (req.burst == BURST_FIXED) begin
                addr = req.addr;
            end else if (wrap) begin
                addr = low + ((req.addr - low + axi_addr_t'(b) * step) % bound);
            end else begin
                addr = req.addr + axi_addr_t'(b) * step;
            end
            data = beat_q[b];
            for (k = 0; k < int'(step); k++) begin
                idx        = MEM_AW'((addr + axi_addr_t'(k)) % axi_addr_t'(MEM_BYTES));
                model[idx] = data[8*k +: 8];
                touched_q.push_back(idx);
            end
        end
    endfunction

    task automatic compare_value(input string name, input logic [47:0] expected,
                                 input logic [47:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
        end
    endtask

    task automatic issue_request(input ar_req_t req);
        req_i       = req;
        req_valid_i = 1'b1;
        @(negedge clk);
        req_valid_i = 1'b0;
    endtask

    // R channel slave with random gaps that holds each beat until RREADY
    task automatic send_beats(input ar_req_t req, input axi_resp_t mid_resp);
        int b;
        int gap;
        int waits;
        int exp_waits;
        rready_miss = 0;
        for (b = 0; b <= int'(req.len); b++) begin
            rvalid_i = 1'b0;
            gap = next_rand() % 3;
            repeat (gap) @(negedge clk);
            rbeat_i.id   = req.id;
            rbeat_i.data = next_rand();
            rbeat_i.resp = beat_resp(b, mid_resp);
            rbeat_i.last = (b == int'(req.len));
            rvalid_i     = 1'b1;
            beat_q.push_back(rbeat_i.data);
            // A beat right after the previous one also sits out the one-cycle gap
            exp_waits = (b > 0 && gap == 0) ? 2 : 1;
            waits     = 0;
            do begin
                @(negedge clk);
                waits++;
            end while (!rready_o);
            if (waits != exp_waits) begin
                rready_miss++;
            end
            @(negedge clk);
        end
        rvalid_i = 1'b0;
        rbeat_i  = '0;
    endtask

    task automatic start_compare(input string name);
        cmp_name = name;
        cmp_req++;
        wait (cmp_done == cmp_req);
    endtask

    task automatic run_burst(input string name, input ar_req_t req, input axi_resp_t mid_resp,
                             input logic extra_strobe);
        int        done_start;
        int        b;
        axi_resp_t worst;
        done_start = done_cnt;
        exp_ar_cnt = ar_cnt + 1;
        beat_q.delete();
        issue_request(req);
        while (!arvalid_o) @(negedge clk);
        seen_ar    = ar_o;
        busy_at_ar = busy_o;
        repeat (next_rand() % 4) @(negedge clk);
        arready_i = 1'b1;
        @(negedge clk);
        arready_i = 1'b0;
        if (extra_strobe) begin
            issue_request(req);
        end
        send_beats(req, mid_resp);
        while (done_cnt == done_start) @(negedge clk);
        worst = RESP_OKAY;
        for (b = 0; b <= int'(req.len); b++) begin
            if (beat_resp(b, mid_resp) > worst) begin
                worst = beat_resp(b, mid_resp);
            end
        end
        apply_burst(req);
        exp_req     = req;
        exp_resp    = worst;
        ar_expected = 1'b1;
        start_compare(name);
    endtask

    task automatic run_reject(input string name, input ar_req_t req);
        int done_start;
        done_start = done_cnt;
        exp_ar_cnt = ar_cnt;
        busy_seen  = 1'b0;
        issue_request(req);
        while (done_cnt == done_start) begin
            busy_seen = busy_seen | busy_o | arvalid_o;
            @(negedge clk);
        end
        repeat (4) begin
            busy_seen = busy_seen | busy_o | arvalid_o;
            @(negedge clk);
        end
        touched_q.delete();
        exp_resp    = RESP_SLVERR;
        ar_expected = 1'b0;
        start_compare(name);
    endtask

    initial begin : readback
        int err_start;
        mem_raddr_i = '0;
        forever begin
            wait (cmp_req != cmp_done);
            err_start = errors;
            if (ar_expected) begin
                compare_value($sformatf("%s AR payload", cmp_name), 48'(exp_req), 48'(seen_ar));
                compare_value($sformatf("%s busy with AR", cmp_name), 48'(1), 48'(busy_at_ar));
                compare_value($sformatf("%s busy at done", cmp_name), 48'(0), 48'(done_busy));
                compare_value($sformatf("%s RREADY timing misses", cmp_name), 48'(0),
                              48'(rready_miss));
            end else begin
                compare_value($sformatf("%s busy on reject", cmp_name), 48'(0), 48'(busy_seen));
            end
            compare_value($sformatf("%s resp", cmp_name), 48'(exp_resp), 48'(done_resp));
            foreach (touched_q[i]) begin
                mem_raddr_i = touched_q[i];
                @(negedge clk);
                compare_value($sformatf("%s byte 0x%03h", cmp_name, touched_q[i]),
                              48'(model[touched_q[i]]), 48'(mem_rdata_o));
            end
            // Late enough to catch a stray second AR
            compare_value($sformatf("%s AR count", cmp_name), 48'(exp_ar_cnt), 48'(ar_cnt));
            tests++;
            $display("Test %s finished with %0d errors", cmp_name, errors - err_start);
            cmp_done = cmp_req;
        end
    end

    initial begin : stimulus
        rst_n       = 1'b0;
        req_i       = '0;
        req_valid_i = 1'b0;
        arready_i   = 1'b0;
        rbeat_i     = '0;
        rvalid_i    = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        run_burst("incr_len7", build_req(4'd1, 32'h0000_0040, 4'd7, 3'd2, BURST_INCR),
                  RESP_OKAY, 1'b0);
        run_burst("wrap_size0", build_req(4'd2, 32'h0000_0105, 4'd15, 3'd0, BURST_WRAP),
                  RESP_OKAY, 1'b0);
        run_burst("wrap_size1", build_req(4'd3, 32'h0000_020A, 4'd3, 3'd1, BURST_WRAP),
                  RESP_OKAY, 1'b0);
        run_burst("wrap_size2", build_req(4'd4, 32'h0000_0318, 4'd3, 3'd2, BURST_WRAP),
                  RESP_OKAY, 1'b0);
        run_burst("fixed_len3", build_req(4'd5, 32'h0000_0500, 4'd3, 3'd2, BURST_FIXED),
                  RESP_OKAY, 1'b0);
        run_burst("resp_worst", build_req(4'd6, 32'h0000_0600, 4'd2, 3'd2, BURST_INCR),
                  RESP_SLVERR, 1'b0);
        run_reject("size3_reject", build_req(4'd7, 32'h0000_0700, 4'd1, 3'd3, BURST_INCR));
        run_burst("strobe_busy", build_req(4'd8, 32'h0000_0720, 4'd3, 3'd1, BURST_INCR),
                  RESP_OKAY, 1'b1);
        run_burst("addr_modulo", build_req(4'd9, 32'h0001_2FF8, 4'd3, 3'd2, BURST_INCR),
                  RESP_OKAY, 1'b0);
        $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- verif/axi_rd_master_properties.sv
`timescale 1ns/1ps

module axi_rd_master_properties (
    input logic             clk,
    input logic             rst_n,
    input axi_pkg::ar_req_t ar_i,
    input logic             arvalid_i,
    input logic             arready_i,
    input logic             rready_i,
    input logic             done_i
);

    // AR request holds until the slave accepts it
    ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid_i && !arready_i |=> arvalid_i && $stable(ar_i))
        else $error("ARVALID or AR payload changed before ARREADY");

    rready_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        rready_i |=> !rready_i)
        else $error("RREADY high for two cycles in a row");

    done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        done_i |=> !done_i)
        else $error("done_o longer than one cycle");

    // Channel outputs quiet while reset is held
    reset_quiet: assert property (@(posedge clk)
        !rst_n |-> !arvalid_i && !rready_i && !done_i)
        else $error("ARVALID, RREADY or done_o high during reset");

endmodule

bind axi_rd_master_top axi_rd_master_properties u_properties (
    .clk       (clk),
    .rst_n     (rst_n),
    .ar_i      (ar_o),
    .arvalid_i (arvalid_o),
    .arready_i (arready_i),
    .rready_i  (rready_o),
    .done_i    (done_o)
);

//--- logic/axi_rd_master_top.sv
`timescale 1ns/1ps

module axi_rd_master_top #(
    parameter int MEM_AW = mem_pkg::MEM_AW_DEF
) (
    input  logic               clk,
    input  logic               rst_n,
    input  axi_pkg::ar_req_t   req_i,
    input  logic               req_valid_i,
    input  logic               arready_i,
    input  axi_pkg::r_beat_t   rbeat_i,
    input  logic               rvalid_i,
    input  logic [MEM_AW-1:0]  mem_raddr_i,
    output axi_pkg::ar_req_t   ar_o,
    output logic               arvalid_o,
    output logic               rready_o,
    output logic               busy_o,
    output logic               done_o,
    output axi_pkg::axi_resp_t resp_o,
    output mem_pkg::byte_t     mem_rdata_o
);
    import axi_pkg::*;
    import mem_pkg::*;

    ar_req_t   setup;
    logic      load;
    logic      reject;
    logic      burst_end;
    logic      beat_take;
    axi_data_t beat_data;
    mem_wr_t   mem_wr;

    ar_issue u_ar_issue (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_i       (req_i),
        .req_valid_i (req_valid_i),
        .arready_i   (arready_i),
        .burst_end_i (burst_end),
        .ar_o        (ar_o),
        .arvalid_o   (arvalid_o),
        .busy_o      (busy_o),
        .reject_o    (reject),
        .setup_o     (setup),
        .load_o      (load)
    );

    r_beat_ctrl u_r_beat_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .rbeat_i     (rbeat_i),
        .rvalid_i    (rvalid_i),
        .reject_i    (reject),
        .rready_o    (rready_o),
        .beat_take_o (beat_take),
        .burst_end_o (burst_end),
        .beat_data_o (beat_data),
        .done_o      (done_o),
        .resp_o      (resp_o)
    );

    burst_addr_gen #(
        .MEM_AW (MEM_AW)
    ) u_burst_addr_gen (
        .clk         (clk),
        .rst_n       (rst_n),
        .setup_i     (setup),
        .load_i      (load),
        .beat_take_i (beat_take),
        .beat_data_i (beat_data),
        .wr_o        (mem_wr)
    );

    local_mem #(
        .MEM_AW (MEM_AW)
    ) u_local_mem (
        .clk         (clk),
        .wr_i        (mem_wr),
        .wr_en_i     (beat_take),
        .mem_raddr_i (mem_raddr_i),
        .mem_rdata_o (mem_rdata_o)
    );

endmodule

//--- logic/local_mem.sv
`timescale 1ns/1ps

module local_mem #(
    parameter int MEM_AW = mem_pkg::MEM_AW_DEF
) (
    input  logic                clk,
    input  mem_pkg::mem_wr_t    wr_i,
    input  logic                wr_en_i,
    input  logic [MEM_AW-1:0]   mem_raddr_i,
    output mem_pkg::byte_t      mem_rdata_o
);
    import axi_pkg::*;
    import mem_pkg::*;

    localparam int LANES = $bits(axi_data_t) / 8;

    byte_t             mem [2**MEM_AW];
    logic [MEM_AW-1:0] base;

    assign base = MEM_AW'(wr_i.addr);

    // Byte lane k lands at base + k, wrapping at the top of memory
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            for (int k = 0; k < LANES; k++) begin
                if (k < (1 << wr_i.size)) begin
                    mem[base + MEM_AW'(k)] <= wr_i.data[8*k +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        mem_rdata_o <= mem[mem_raddr_i];
    end

endmodule

//--- logic/burst_addr_gen.sv
`timescale 1ns/1ps

module burst_addr_gen #(
    parameter int MEM_AW = mem_pkg::MEM_AW_DEF
) (
    input  logic               clk,
    input  logic               rst_n,
    input  axi_pkg::ar_req_t   setup_i,
    input  logic               load_i,
    input  logic               beat_take_i,
    input  axi_pkg::axi_data_t beat_data_i,
    output mem_pkg::mem_wr_t   wr_o
);
    import axi_pkg::*;
    import mem_pkg::*;

    axi_addr_t         addr_q;
    axi_addr_t         low_q;
    axi_addr_t         mask_q;
    axi_size_t         size_q;
    axi_burst_t        burst_q;
    logic              wrap_ok;
    axi_addr_t         boundary;
    axi_addr_t         step;
    axi_addr_t         next_addr;
    logic [MEM_AW-1:0] local_addr;

    // Wrapping needs 2, 4, 8 or 16 beats
    assign wrap_ok  = setup_i.len inside {4'd1, 4'd3, 4'd7, 4'd15};
    assign boundary = (axi_addr_t'(setup_i.len) + 32'd1) << setup_i.size;

    assign step = axi_addr_t'(1) << size_q;

    always_comb begin
        case (burst_q)
            BURST_FIXED: next_addr = addr_q;
            BURST_WRAP:  next_addr = low_q + ((addr_q + step - low_q) & mask_q);
            default:     next_addr = addr_q + step;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr_q  <= '0;
            low_q   <= '0;
            mask_q  <= '0;
            size_q  <= '0;
            burst_q <= BURST_INCR;
        end else if (load_i) begin
            addr_q <= setup_i.addr;
            low_q  <= setup_i.addr & ~(boundary - 32'd1);
            mask_q <= boundary - 32'd1;
            size_q <= setup_i.size;
            if (setup_i.burst == BURST_WRAP && !wrap_ok) begin
                burst_q <= BURST_INCR;
            end else begin
                burst_q <= setup_i.burst;
            end
        end else if (beat_take_i) begin
            addr_q <= next_addr;
        end
    end

    // Local address is the beat address modulo the memory size
    assign local_addr = addr_q[MEM_AW-1:0];

    always_comb begin
        wr_o.addr = MEM_AW_DEF'(local_addr);
        wr_o.data = beat_data_i;
        wr_o.size = size_q;
    end

endmodule

//--- logic/r_beat_ctrl.sv
`timescale 1ns/1ps

module r_beat_ctrl (
    input  logic               clk,
    input  logic               rst_n,
    input  axi_pkg::r_beat_t   rbeat_i,
    input  logic               rvalid_i,
    input  logic               reject_i,
    output logic               rready_o,
    output logic               beat_take_o,
    output logic               burst_end_o,
    output axi_pkg::axi_data_t beat_data_o,
    output logic               done_o,
    output axi_pkg::axi_resp_t resp_o
);
    import axi_pkg::*;

    typedef enum logic [1:0] {
        R_WAIT,
        R_ACCEPT,
        R_GAP
    } r_state_e;

    r_state_e  state_q;
    axi_resp_t worst_q;
    axi_resp_t worst_next;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= R_WAIT;
        end else begin
            case (state_q)
                R_WAIT: begin
                    if (rvalid_i) begin
                        state_q <= R_ACCEPT;
                    end
                end
                R_ACCEPT: begin
                    state_q <= R_GAP;
                end
                default: begin
                    state_q <= R_WAIT;
                end
            endcase
        end
    end

    // RREADY is a single-cycle pulse, one cycle after RVALID is seen
    assign rready_o    = (state_q == R_ACCEPT);
    assign beat_take_o = rready_o && rvalid_i;
    assign burst_end_o = beat_take_o && rbeat_i.last;
    assign beat_data_o = rbeat_i.data;

    assign worst_next = (rbeat_i.resp > worst_q) ? rbeat_i.resp : worst_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            worst_q <= RESP_OKAY;
            done_o  <= 1'b0;
            resp_o  <= RESP_OKAY;
        end else begin
            done_o <= burst_end_o || reject_i;
            if (reject_i) begin
                resp_o <= RESP_SLVERR;
            end
            if (beat_take_o) begin
                if (rbeat_i.last) begin
                    // Restart accumulation for the next burst
                    worst_q <= RESP_OKAY;
                    resp_o  <= worst_next;
                end else begin
                    worst_q <= worst_next;
                end
            end
        end
    end

endmodule

//--- logic/ar_issue.sv
`timescale 1ns/1ps

module ar_issue (
    input  logic             clk,
    input  logic             rst_n,
    input  axi_pkg::ar_req_t req_i,
    input  logic             req_valid_i,
    input  logic             arready_i,
    input  logic             burst_end_i,
    output axi_pkg::ar_req_t ar_o,
    output logic             arvalid_o,
    output logic             busy_o,
    output logic             reject_o,
    output axi_pkg::ar_req_t setup_o,
    output logic             load_o
);
    import axi_pkg::*;

    typedef enum logic [1:0] {
        AR_IDLE,
        AR_VALID,
        AR_WAIT_DATA
    } ar_state_e;

    ar_state_e state_q;
    ar_req_t   req_q;
    logic      req_take;
    logic      size_ok;

    // Strobes are only taken while idle
    assign req_take = req_valid_i && (state_q == AR_IDLE);
    assign size_ok  = (req_i.size <= MAX_SIZE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q  <= AR_IDLE;
            reject_o <= 1'b0;
        end else begin
            reject_o <= req_take && !size_ok;
            case (state_q)
                AR_IDLE: begin
                    if (req_take && size_ok) begin
                        state_q <= AR_VALID;
                    end
                end
                AR_VALID: begin
                    if (arready_i) begin
                        state_q <= AR_WAIT_DATA;
                    end
                end
                AR_WAIT_DATA: begin
                    if (burst_end_i) begin
                        state_q <= AR_IDLE;
                    end
                end
                default: begin
                    state_q <= AR_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (req_take && size_ok) begin
            req_q <= req_i;
        end
    end

    assign ar_o      = req_q;
    assign arvalid_o = (state_q == AR_VALID);
    assign busy_o    = (state_q != AR_IDLE);

    // Burst setup goes to the address generator at the AR handshake
    assign setup_o = req_q;
    assign load_o  = arvalid_o && arready_i;

endmodule

//--- logic/mem_pkg.sv
package mem_pkg;

    typedef logic [7:0] byte_t;

    // 4 KB local memory by default
    localparam int MEM_AW_DEF = 12;

    // One beat's write into the local memory
    typedef struct packed {
        logic [MEM_AW_DEF-1:0] addr;
        axi_pkg::axi_data_t    data;
        axi_pkg::axi_size_t    size;
    } mem_wr_t;

endpackage

//--- logic/axi_pkg.sv
package axi_pkg;

    // AXI3 field widths
    typedef logic [3:0]  axi_id_t;
    typedef logic [31:0] axi_addr_t;
    typedef logic [3:0]  axi_len_t;
    typedef logic [2:0]  axi_size_t;
    typedef logic [1:0]  axi_burst_t;
    typedef logic [1:0]  axi_resp_t;
    typedef logic [31:0] axi_data_t;

    localparam axi_burst_t BURST_FIXED = 2'd0;
    localparam axi_burst_t BURST_INCR  = 2'd1;
    localparam axi_burst_t BURST_WRAP  = 2'd2;

    // Ordered by severity, so a larger code is a worse response
    localparam axi_resp_t RESP_OKAY   = 2'd0;
    localparam axi_resp_t RESP_EXOKAY = 2'd1;
    localparam axi_resp_t RESP_SLVERR = 2'd2;
    localparam axi_resp_t RESP_DECERR = 2'd3;

    // Largest beat is 4 bytes
    localparam axi_size_t MAX_SIZE = 3'd2;

    // Read request, also the AR channel payload
    typedef struct packed {
        axi_id_t    id;
        axi_addr_t  addr;
        axi_len_t   len;
        axi_size_t  size;
        axi_burst_t burst;
    } ar_req_t;

    // One beat on the R channel
    typedef struct packed {
        axi_id_t   id;
        axi_data_t data;
        axi_resp_t resp;
        logic      last;
    } r_beat_t;

endpackage
